// File: hdl/beat_counter.sv
// Byte beat counter
`default_nettype none

`include "pin_bus_macros.svh"

module beat_counter (
  input  wire                      clk,
  input  wire                      rst,
  input  pin_bus_pkg::seq_state_t  state,
  output pin_bus_pkg::beat_idx_t   beat,
  output logic                     last_beat
);

  logic active; // Current state moves bytes over the pins

  assign active = (state == pin_bus_pkg::ST_ADDR)  ||
                  (state == pin_bus_pkg::ST_WDATA) ||
                  (state == pin_bus_pkg::ST_RDATA);

  assign last_beat = active && (beat == pin_bus_pkg::beat_idx_t'(`PB_BEATS - 1));

  // The final beat coincides with the phase change, so clearing there
  // starts the next phase at beat 0
  always_ff @(posedge clk) begin
    if (rst) begin
      beat <= '0;
    end else if (active && !last_beat) begin
      beat <= beat + 1'b1;
    end else begin
      beat <= '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/bus_sequencer.sv
// Transaction sequencer FSM
`default_nettype none

module bus_sequencer (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      req_valid,
  input  wire                      req_we,
  input  wire                      last_beat,
  output pin_bus_pkg::seq_state_t  state,
  output logic                     load,
  output logic                     busy,
  output logic                     done
);

  pin_bus_pkg::seq_state_t state_nxt;
  logic                    we_q; // Write flag of the transaction in flight

  // Requests only count while idle, anything else is dropped
  assign load = req_valid && (state == pin_bus_pkg::ST_IDLE);

  always_comb begin
    state_nxt = state;
    unique case (state)
      pin_bus_pkg::ST_IDLE: begin
        if (load) begin
          state_nxt = pin_bus_pkg::ST_ADDR;
        end
      end
      pin_bus_pkg::ST_ADDR: begin
        if (last_beat) begin
          state_nxt = we_q ? pin_bus_pkg::ST_WDATA : pin_bus_pkg::ST_RDATA;
        end
      end
      pin_bus_pkg::ST_WDATA: begin
        if (last_beat) begin
          state_nxt = pin_bus_pkg::ST_DONE;
        end
      end
      pin_bus_pkg::ST_RDATA: begin
        if (last_beat) begin
          state_nxt = pin_bus_pkg::ST_DONE;
        end
      end
      pin_bus_pkg::ST_DONE: begin
        state_nxt = pin_bus_pkg::ST_IDLE; // Single cycle completion
      end
      default: begin
        state_nxt = pin_bus_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= pin_bus_pkg::ST_IDLE;
      we_q  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (load) begin
        we_q <= req_we; // Captured with the request
      end
    end
  end

  // Busy covers every phase including done, so it drops the cycle after done
  assign busy = (state != pin_bus_pkg::ST_IDLE);
  assign done = (state == pin_bus_pkg::ST_DONE);

endmodule

`default_nettype wire

// File: hdl/in_deserializer.sv
// Read data deserializer
`default_nettype none

`include "pin_bus_macros.svh"

module in_deserializer (
  input  wire                      clk,
  input  wire                      rst,
  input  pin_bus_pkg::seq_state_t  state,
  input  pin_bus_pkg::beat_idx_t   beat,
  input  pin_bus_pkg::pin_byte_t   pin_in,
  output pin_bus_pkg::word_t       rdata
);

  // Each read beat lands in its own byte lane, last lane is in by done
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else if (state == pin_bus_pkg::ST_RDATA) begin
      rdata[beat*`PB_PIN_W +: `PB_PIN_W] <= pin_in;
    end
  end

endmodule

`default_nettype wire

// File: hdl/out_serializer.sv
// Address and write data serializer
`default_nettype none

`include "pin_bus_macros.svh"

module out_serializer (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      load,
  input  pin_bus_pkg::word_t       addr,
  input  pin_bus_pkg::word_t       wdata,
  input  pin_bus_pkg::seq_state_t  state,
  input  pin_bus_pkg::beat_idx_t   beat,
  output pin_bus_pkg::pin_out_t    pins
);

  pin_bus_pkg::word_t    addr_q;
  pin_bus_pkg::word_t    wdata_q;
  pin_bus_pkg::word_t    word_sel;  // Word of the current phase
  pin_bus_pkg::pin_byte_t byte_sel;
  logic                  out_phase;

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q  <= '0;
      wdata_q <= '0;
    end else if (load) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  assign out_phase = (state == pin_bus_pkg::ST_ADDR) ||
                     (state == pin_bus_pkg::ST_WDATA);

  assign word_sel = (state == pin_bus_pkg::ST_ADDR) ? addr_q : wdata_q;
  assign byte_sel = word_sel[beat*`PB_PIN_W +: `PB_PIN_W]; // LSB first

  always_comb begin
    pins.data       = out_phase ? byte_sel : '0;
    pins.oe         = out_phase;
    pins.strobe     = out_phase || (state == pin_bus_pkg::ST_RDATA);
    pins.addr_phase = (state == pin_bus_pkg::ST_ADDR);
  end

endmodule

`default_nettype wire

// File: hdl/pin_bridge_top.sv
// Pin bus bridge top
`default_nettype none

module pin_bridge_top (
  input  wire                     clk,
  input  wire                     rst,
  input  pin_bus_pkg::bus_req_t   req,
  input  pin_bus_pkg::pin_byte_t  pin_in,
  output logic                    busy,
  output pin_bus_pkg::bus_rsp_t   rsp,
  output pin_bus_pkg::pin_out_t   pins
);

  pin_bus_pkg::seq_state_t state;
  pin_bus_pkg::beat_idx_t  beat;
  pin_bus_pkg::word_t      rdata;
  logic                    load;
  logic                    last_beat;
  logic                    done;

  bus_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req.valid),
    .req_we    (req.we),
    .last_beat (last_beat),
    .state     (state),
    .load      (load),
    .busy      (busy),
    .done      (done)
  );

  beat_counter u_beat (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .beat      (beat),
    .last_beat (last_beat)
  );

  out_serializer u_ser (
    .clk   (clk),
    .rst   (rst),
    .load  (load),
    .addr  (req.addr),
    .wdata (req.wdata),
    .state (state),
    .beat  (beat),
    .pins  (pins)
  );

  in_deserializer u_deser (
    .clk    (clk),
    .rst    (rst),
    .state  (state),
    .beat   (beat),
    .pin_in (pin_in),
    .rdata  (rdata)
  );

  assign rsp = {done, rdata}; // Completion with read word

endmodule

`default_nettype wire

// File: hdl/pin_bus_macros.svh
// Pin bus width macros
`ifndef PIN_BUS_MACROS_SVH
`define PIN_BUS_MACROS_SVH

// Processor side word, used for both address and data
`define PB_WORD_W 32

// External pin port
`define PB_PIN_W 8

// Byte beats needed to move one word over the pins
`define PB_BEATS 4

// Width of a beat index within one phase
`define PB_BEAT_W 2

`endif

// File: hdl/pin_bus_pkg.sv
// Pin bus shared types
`default_nettype none

`include "pin_bus_macros.svh"

package pin_bus_pkg;

  typedef logic [`PB_WORD_W-1:0] word_t;     // Address or data word
  typedef logic [`PB_PIN_W-1:0]  pin_byte_t; // One byte on the pins
  typedef logic [`PB_BEAT_W-1:0] beat_idx_t; // Beat number within a phase

  // Sequencer phases of one transaction
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_ADDR  = 3'd1,
    ST_WDATA = 3'd2,
    ST_RDATA = 3'd3,
    ST_DONE  = 3'd4
  } seq_state_t;

  // Master request, valid is a one cycle strobe
  typedef struct packed {
    logic  valid;
    logic  we;    // High for write
    word_t addr;
    word_t wdata;
  } bus_req_t;

  // Completion back to the master
  typedef struct packed {
    logic  done;  // One cycle pulse
    word_t rdata; // Valid with done on reads
  } bus_rsp_t;

  // Outgoing pin bundle
  typedef struct packed {
    pin_byte_t data;
    logic      oe;         // Bridge drives the byte lane
    logic      strobe;     // One cycle per beat
    logic      addr_phase; // Address beats
  } pin_out_t;

endpackage

`default_nettype wire

// File: verif/pin_bridge_checker.sv
// Pin protocol assertions
`default_nettype none

`include "pin_bus_macros.svh"

module pin_bridge_checker (
  input wire                     clk,
  input wire                     rst,
  input pin_bus_pkg::bus_req_t   req,
  input wire                     busy,
  input pin_bus_pkg::bus_rsp_t   rsp,
  input pin_bus_pkg::pin_out_t   pins
);

  int unsigned fail_count = 0; // Assertion failures so far
  logic        wr_txn;         // Accepted transaction is a write

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_txn <= 1'b0;
    end else if (req.valid && !busy) begin
      wr_txn <= req.we;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    rst |=> (!busy && !rsp.done && !pins.strobe && !pins.oe))
    else begin
      fail_count++;
      $error("Outputs active after reset");
    end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    (req.valid && !busy) |-> ##9 rsp.done)
    else begin
      fail_count++;
      $error("Done not 9 cycles after accept");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    rsp.done |=> !rsp.done)
    else begin
      fail_count++;
      $error("Done longer than one cycle");
    end

  a_busy_drop: assert property (@(posedge clk) disable iff (rst)
    rsp.done |=> !busy)
    else begin
      fail_count++;
      $error("Busy still high after done");
    end

  // Four driven address beats, then the flag drops
  a_addr_beats: assert property (@(posedge clk) disable iff (rst)
    $rose(pins.addr_phase) |->
      (pins.addr_phase && pins.strobe && pins.oe) [*`PB_BEATS] ##1 !pins.addr_phase)
    else begin
      fail_count++;
      $error("Address phase not four driven beats");
    end

  a_write_oe: assert property (@(posedge clk) disable iff (rst)
    (pins.strobe && wr_txn) |-> pins.oe)
    else begin
      fail_count++;
      $error("Output enable low in a write");
    end

  a_read_oe: assert property (@(posedge clk) disable iff (rst)
    (pins.strobe && !pins.addr_phase && !wr_txn) |-> !pins.oe)
    else begin
      fail_count++;
      $error("Output enable high on a read beat");
    end

endmodule

bind pin_bridge_top pin_bridge_checker u_checker (
  .clk  (clk),
  .rst  (rst),
  .req  (req),
  .busy (busy),
  .rsp  (rsp),
  .pins (pins)
);

`default_nettype wire

// File: verif/tb_clock.sv
// Testbench clock source
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 2; // Period of 4

  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: verif/tb_pin_bridge.sv
// Pin bridge testbench
`default_nettype none

`include "pin_bus_macros.svh"

module tb_pin_bridge;

  localparam int NUM_TXN    = 30;
  localparam int WAIT_LIMIT = 40; // Cycles per wait
  localparam int POOL_SIZE  = 8;  // Few addresses so reads hit earlier writes
  localparam pin_bus_pkg::word_t RD_PATTERN = 32'h5a5a_a5a5;

  logic                   clk;
  logic                   rst;
  pin_bus_pkg::bus_req_t  req;
  pin_bus_pkg::pin_byte_t pin_in;
  logic                   busy;
  pin_bus_pkg::bus_rsp_t  rsp;
  pin_bus_pkg::pin_out_t  pins;

  pin_bus_pkg::word_t mem [pin_bus_pkg::word_t]; // Last data written per address
  pin_bus_pkg::word_t addr_pool [POOL_SIZE];
  pin_bus_pkg::word_t seen_addr;  // Rebuilt from address beats
  pin_bus_pkg::word_t seen_wdata; // Rebuilt from write beats
  pin_bus_pkg::word_t rd_word;
  int                 phase_beat; // Beat count of the model, 0 to 7
  int                 lane;
  int                 strobe_cnt;
  int                 done_cnt;
  int                 errors;
  int                 n;

  tb_clock u_clk (.clk(clk));

  pin_bridge_top DUT (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .pin_in (pin_in),
    .busy   (busy),
    .rsp    (rsp),
    .pins   (pins)
  );

  function automatic pin_bus_pkg::word_t model_word(input pin_bus_pkg::word_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ RD_PATTERN;
  endfunction

  task automatic check_word(input string name, input pin_bus_pkg::word_t exp,
                            input pin_bus_pkg::word_t act);
    assert (act == exp) else begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // Leaves the caller just after a rising edge with busy low
  task automatic wait_idle();
    int i;
    i = 0;
    @(posedge clk);
    #1;
    while (busy && i < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      i++;
    end
    if (busy) begin
      errors++;
      $display("Timeout waiting for busy to fall");
    end
  endtask

  task automatic run_txn(input logic we, input pin_bus_pkg::word_t addr,
                         input pin_bus_pkg::word_t wdata, input logic poke);
    pin_bus_pkg::word_t exp_rdata;
    int                 strobes0;
    int                 dones0;
    int                 cyc;
    wait_idle();
    exp_rdata = model_word(addr);
    strobes0  = strobe_cnt;
    dones0    = done_cnt;
    req.valid = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.wdata = wdata;
    @(posedge clk);
    #1;
    req.valid = 1'b0;
    cyc = 1; // Cycle count from the request cycle
    if (poke) begin
      @(posedge clk);
      #1;
      assert (busy) else begin
        errors++;
        $display("Busy low during a transaction");
      end
      req.valid = 1'b1; // Must be ignored
      req.we    = ~we;
      req.addr  = $urandom;
      req.wdata = $urandom;
      @(posedge clk);
      #1;
      req.valid = 1'b0;
      cyc = 3;
    end
    @(negedge clk);
    while (!rsp.done && cyc < WAIT_LIMIT) begin
      @(negedge clk);
      cyc++;
    end
    if (!rsp.done) begin
      errors++;
      $display("Timeout waiting for done");
      return;
    end
    check_word("latency", 9, cyc);
    check_word("address", addr, seen_addr);
    if (we) begin
      check_word("write data", wdata, seen_wdata);
    end else begin
      check_word("read data", exp_rdata, rsp.rdata);
    end
    check_word("strobe count", 2 * `PB_BEATS, strobe_cnt - strobes0);
    check_word("done count", 1, done_cnt - dones0);
  endtask

  // External memory model, follows the pins just after each edge
  always @(posedge clk) begin
    #1;
    if (rst) begin
      phase_beat = 0;
      pin_in     = '0;
    end else if (pins.strobe) begin
      lane = phase_beat % `PB_BEATS;
      assert (pins.addr_phase == (phase_beat < `PB_BEATS)) else begin
        errors++;
        $display("Address phase flag wrong on beat %0d", phase_beat);
      end
      if (pins.addr_phase) begin
        seen_addr[lane*`PB_PIN_W +: `PB_PIN_W] = pins.data;
      end else if (pins.oe) begin
        seen_wdata[lane*`PB_PIN_W +: `PB_PIN_W] = pins.data;
        if (lane == `PB_BEATS - 1) begin
          mem[seen_addr] = seen_wdata; // Word complete
        end
      end else begin
        rd_word = model_word(seen_addr);
        pin_in  = rd_word[lane*`PB_PIN_W +: `PB_PIN_W]; // Sampled at the next edge
      end
      phase_beat++;
      strobe_cnt++;
    end else begin
      phase_beat = 0;
      pin_in     = pin_bus_pkg::pin_byte_t'($urandom); // Junk outside read beats
    end
    if (rsp.done) begin
      done_cnt++;
    end
  end

  initial begin
    #5000;
    $display("Watchdog expired before the test finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'heeb7e5e0));
    errors     = 0;
    strobe_cnt = 0;
    done_cnt   = 0;
    phase_beat = 0;
    seen_addr  = '0;
    seen_wdata = '0;
    req        = '0;
    pin_in     = '0;
    rst        = 1'b1;
    for (n = 0; n < POOL_SIZE; n++) begin
      addr_pool[n] = $urandom;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (n = 0; n < NUM_TXN; n++) begin
      run_txn(1'($urandom_range(1, 0)), addr_pool[$urandom_range(POOL_SIZE - 1, 0)],
              $urandom, (n == NUM_TXN / 2));
    end
    wait_idle();
    // Whole run, so activity left over after a done is caught too
    check_word("total strobes", 2 * `PB_BEATS * NUM_TXN, strobe_cnt);
    check_word("total dones", NUM_TXN, done_cnt);
    $display("Checks done: %0d testbench errors, %0d assertion failures",
             errors, DUT.u_checker.fail_count);
    if (errors == 0 && DUT.u_checker.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/pin_bus_pkg.sv
hdl/bus_sequencer.sv
hdl/beat_counter.sv
hdl/out_serializer.sv
hdl/in_deserializer.sv
hdl/pin_bridge_top.sv
verif/tb_clock.sv
verif/pin_bridge_checker.sv
verif/tb_pin_bridge.sv
